/* Makefile */
# Verilator build and run of the 64b/66b pcs testbench

VERILATOR ?= verilator
TOP       ?= pcs_loop_tb
FLIST     ?= pcs_loop_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/pcs_block_lock.sv */
`default_nettype none

module pcs_block_lock (
        input  wire       logic_clk,
        input  wire       rst_n_i,
        input  wire [1:0] hdr_i,
        output logic      lock_o
);
        import pcs_line_pkg::*;
        import pcs_lane_pkg::*;

        typedef enum logic {
                LOCK_HUNT,                              // counting good headers in a row
                LOCK_OK                                 // counting bad headers per window
        } lock_state_e;

        lock_state_e         state_q;
        logic [LOCK_CNT_W-1:0] cnt_q;                   // run length in hunt, window slot when locked
        logic [LOCK_BAD_W-1:0] bad_q;                   // bad headers seen in this window
        logic                hdr_ok;

        assign hdr_ok = (hdr_i == SYNC_DATA) || (hdr_i == SYNC_CTRL);
        assign lock_o = (state_q == LOCK_OK);

        always_ff @(posedge logic_clk) begin
                if (!rst_n_i) begin
                        state_q <= LOCK_HUNT;
                        cnt_q   <= '0;
                        bad_q   <= '0;
                end else begin
                        case (state_q)
                        LOCK_HUNT: begin
                                bad_q <= '0;
                                if (!hdr_ok) begin
                                        cnt_q <= '0;            // run broken, start over
                                end else if (cnt_q == LOCK_CNT_W'(LOCK_GOOD_N - 1)) begin
                                        state_q <= LOCK_OK;
                                        cnt_q   <= '0;
                                end else begin
                                        cnt_q <= cnt_q + 1'b1;
                                end
                        end
                        LOCK_OK: begin
                                if (!hdr_ok && bad_q == LOCK_BAD_W'(LOCK_BAD_N - 1)) begin
                                        state_q <= LOCK_HUNT;   // too many in one window
                                        cnt_q   <= '0;
                                        bad_q   <= '0;
                                end else if (cnt_q == LOCK_CNT_W'(LOCK_WIN_N - 1)) begin
                                        cnt_q <= '0;            // window done, fresh count
                                        bad_q <= '0;
                                end else begin
                                        cnt_q <= cnt_q + 1'b1;
                                        bad_q <= bad_q + LOCK_BAD_W'(!hdr_ok);
                                end
                        end
                        default: state_q <= LOCK_HUNT;
                        endcase
                end
        end

endmodule

`default_nettype wire

/* hdl/pcs_lane_pkg.sv */
`default_nettype none

package pcs_lane_pkg;

        // mac side lane word, one per cycle
        typedef struct packed {
                logic        ctrl;                      // 0 on a plain data word
                logic        idle;                      // idle word, nothing kept
                logic [1:0]  start;                     // [0] lane 0, [1] lane 4
                logic        term;                      // terminate, keep gives the byte count
                logic        err;                       // error word
                logic [63:0] data;                      // byte 0 in [7:0]
                logic [7:0]  keep;                      // one bit per valid byte
        } pcs_lane_t;

        // block lock thresholds
        localparam int LOCK_GOOD_N = 64;                // consecutive good headers to lock
        localparam int LOCK_WIN_N  = 64;                // headers per loss window
        localparam int LOCK_BAD_N  = 16;                // bad headers per window to drop lock

        localparam int LOCK_CNT_W = $clog2(LOCK_GOOD_N > LOCK_WIN_N ? LOCK_GOOD_N : LOCK_WIN_N);
        localparam int LOCK_BAD_W = $clog2(LOCK_BAD_N);

endpackage

`default_nettype wire

/* hdl/pcs_line_pkg.sv */
`default_nettype none

package pcs_line_pkg;

        // sync header values, anything else is an invalid header
        localparam logic [1:0] SYNC_DATA = 2'b01;       // eight data bytes follow
        localparam logic [1:0] SYNC_CTRL = 2'b10;       // type byte plus control payload

        typedef struct packed {
                logic [1:0]  hdr;                       // sync header
                logic [63:0] payload;                   // type byte in [7:0] on control blocks
        } pcs_block_t;

        // block type field, only the subset carried by this pcs
        typedef enum logic [7:0] {
                BT_IDLE   = 8'h1e,                      // eight control codes
                BT_START0 = 8'h78,                      // start in lane 0
                BT_START4 = 8'h33,                      // four idles then start in lane 4
                BT_TERM0  = 8'h87,
                BT_TERM1  = 8'h99,
                BT_TERM2  = 8'haa,
                BT_TERM3  = 8'hb4,
                BT_TERM4  = 8'hcc,
                BT_TERM5  = 8'hd2,
                BT_TERM6  = 8'he1,
                BT_TERM7  = 8'hff                       // seven bytes then terminate
        } block_type_e;

        // terminate type indexed by the number of data bytes before it
        localparam block_type_e TERM_TYPES [8] = '{
                BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
                BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7
        };

        localparam logic [6:0]  CODE_IDLE = 7'h00;      // 7-bit idle control code
        localparam logic [6:0]  CODE_ERR  = 7'h1e;      // 7-bit error control code

        localparam logic [63:0] IDLE_PAYLOAD = {{8{CODE_IDLE}}, BT_IDLE};
        localparam logic [63:0] ERR_PAYLOAD  = {{8{CODE_ERR}}, BT_IDLE};

        // x^58 + x^39 + 1
        localparam int SCR_LEN = 58;
        localparam int SCR_TAP = 39;
        localparam logic [SCR_LEN-1:0] SCR_INIT = '1;   // state after reset

endpackage

`default_nettype wire

/* hdl/pcs_loop_top.sv */
`default_nettype none

module pcs_loop_top (
        input  wire                      logic_clk,
        input  wire                      rst_n_i,
        input  wire                      loopback_i,    // level, rx words replace mac_tx_i
        input  wire pcs_lane_pkg::pcs_lane_t  mac_tx_i,
        input  wire pcs_line_pkg::pcs_block_t serdes_rx_i,
        output pcs_line_pkg::pcs_block_t      serdes_tx_o,
        output pcs_lane_pkg::pcs_lane_t       mac_rx_o,
        output logic                     mac_rx_valid_o,
        output logic                     block_lock_o
);
        import pcs_line_pkg::*;
        import pcs_lane_pkg::*;

        pcs_lane_t  loop_q;                             // decoded word, one flop before tx
        pcs_lane_t  enc_lane;
        pcs_block_t enc_blk;                            // encoder to scrambler
        pcs_block_t rx_blk;                             // descrambler to decoder
        logic       lock_q;                             // lock lined up with mac_rx_o

        always_ff @(posedge logic_clk) begin
                loop_q <= mac_rx_o;
        end

        assign enc_lane = loopback_i ? loop_q : mac_tx_i;

        // tx: encode then scramble, 2 cycles
        pcs_tx_encode m_tx_encode (
                .logic_clk (logic_clk),
                .rst_n_i   (rst_n_i),
                .lane_i    (enc_lane),
                .blk_o     (enc_blk)
        );

        pcs_scrambler #(.DESCRAMBLE(1'b0)) m_tx_scr (
                .logic_clk (logic_clk),
                .rst_n_i   (rst_n_i),
                .blk_i     (enc_blk),
                .blk_o     (serdes_tx_o)
        );

        // rx: descramble then decode, 2 cycles
        pcs_scrambler #(.DESCRAMBLE(1'b1)) m_rx_scr (
                .logic_clk (logic_clk),
                .rst_n_i   (rst_n_i),
                .blk_i     (serdes_rx_i),
                .blk_o     (rx_blk)
        );

        pcs_rx_decode m_rx_decode (
                .logic_clk (logic_clk),
                .rst_n_i   (rst_n_i),
                .blk_i     (rx_blk),
                .lane_o    (mac_rx_o)
        );

        pcs_block_lock m_block_lock (
                .logic_clk (logic_clk),
                .rst_n_i   (rst_n_i),
                .hdr_i     (serdes_rx_i.hdr),           // raw header, never scrambled
                .lock_o    (block_lock_o)
        );

        always_ff @(posedge logic_clk) begin
                if (!rst_n_i) begin
                        lock_q <= 1'b0;
                end else begin
                        lock_q <= block_lock_o;
                end
        end

        // drops with the live lock, rises with the aligned one
        assign mac_rx_valid_o = lock_q & block_lock_o;

endmodule

`default_nettype wire

/* hdl/pcs_rx_decode.sv */
`default_nettype none

module pcs_rx_decode (
        input  wire                      logic_clk,
        input  wire                      rst_n_i,
        input  wire pcs_line_pkg::pcs_block_t blk_i,
        output pcs_lane_pkg::pcs_lane_t       lane_o
);
        import pcs_line_pkg::*;
        import pcs_lane_pkg::*;

        block_type_e bt;                                // type byte, may hold an unknown value
        pcs_lane_t   lane_d;
        logic        term_hit;                          // type byte is one of T0..T7

        assign bt = block_type_e'(blk_i.payload[7:0]);

        always_comb begin
                lane_d      = '0;
                lane_d.ctrl = 1'b1;
                term_hit    = 1'b0;
                if (blk_i.hdr == SYNC_DATA) begin
                        lane_d.ctrl = 1'b0;
                        lane_d.data = blk_i.payload;
                        lane_d.keep = 8'hff;
                end else if (blk_i.hdr != SYNC_CTRL) begin
                        lane_d.err = 1'b1;              // 00 or 11 header
                end else begin
                        case (bt)
                        BT_IDLE: begin
                                // all eight codes must be idle, error codes land here too
                                lane_d.idle = (blk_i.payload[63:8] == {8{CODE_IDLE}});
                                lane_d.err  = !lane_d.idle;
                        end
                        BT_START0: begin
                                lane_d.start = 2'b01;
                                lane_d.data  = {blk_i.payload[63:8], 8'h00};
                                lane_d.keep  = 8'hfe;
                        end
                        BT_START4: begin
                                lane_d.start = 2'b10;
                                lane_d.data  = {blk_i.payload[63:40], 40'h0};
                                lane_d.keep  = 8'he0;
                        end
                        default: begin
                                for (int n = 0; n < 8; n++) begin
                                        if (bt == TERM_TYPES[n]) begin
                                                term_hit    = 1'b1;
                                                lane_d.keep = 8'((1 << n) - 1);   // n low bytes
                                        end
                                end
                                for (int i = 0; i < 7; i++) begin
                                        if (lane_d.keep[i])     // byte i sits one up in the block
                                                lane_d.data[8*i +: 8] = blk_i.payload[8*(i+1) +: 8];
                                end
                                lane_d.term = term_hit;
                                lane_d.err  = !term_hit;        // unknown type byte
                        end
                        endcase
                end
        end

        always_ff @(posedge logic_clk) begin
                if (!rst_n_i) begin
                        lane_o <= '0;                   // all flags low
                end else begin
                        lane_o <= lane_d;
                end
        end

endmodule

`default_nettype wire

/* hdl/pcs_scrambler.sv */
`default_nettype none

module pcs_scrambler #(
        parameter bit DESCRAMBLE = 1'b0                 // 1 on the receive side
) (
        input  wire                      logic_clk,
        input  wire                      rst_n_i,
        input  wire pcs_line_pkg::pcs_block_t blk_i,
        output pcs_line_pkg::pcs_block_t      blk_o
);
        import pcs_line_pkg::*;

        logic [SCR_LEN-1:0] state_q;                    // last 58 line bits, newest in [0]
        logic [SCR_LEN-1:0] state_d;
        logic [63:0]        pay_d;

        // one bit per step, lsb first, all 64 within the cycle
        always_comb begin
                state_d = state_q;
                for (int i = 0; i < 64; i++) begin
                        pay_d[i] = blk_i.payload[i] ^ state_d[SCR_TAP-1] ^ state_d[SCR_LEN-1];
                        // the line side bit always enters the state
                        state_d = {state_d[SCR_LEN-2:0], DESCRAMBLE ? blk_i.payload[i] : pay_d[i]};
                end
        end

        always_ff @(posedge logic_clk) begin
                if (!rst_n_i) begin
                        state_q <= SCR_INIT;
                end else begin
                        state_q <= state_d;
                end
        end

        always_ff @(posedge logic_clk) begin
                blk_o.hdr     <= blk_i.hdr;                     // header is never scrambled
                blk_o.payload <= pay_d;
        end

endmodule

`default_nettype wire

/* hdl/pcs_tx_encode.sv */
`default_nettype none

module pcs_tx_encode (
        input  wire                      logic_clk,
        input  wire                      rst_n_i,
        input  wire pcs_lane_pkg::pcs_lane_t  lane_i,
        output pcs_line_pkg::pcs_block_t      blk_o
);
        import pcs_line_pkg::*;
        import pcs_lane_pkg::*;

        pcs_block_t blk_d;
        logic       term_ok;                            // keep is a low contiguous mask, not ff
        logic [3:0] term_n;                             // data bytes before the terminate

        assign term_ok = ((lane_i.keep & (lane_i.keep + 8'd1)) == 8'h00) && (lane_i.keep != 8'hff);
        assign term_n  = 4'($countones(lane_i.keep));

        always_comb begin
                blk_d.hdr     = SYNC_CTRL;
                blk_d.payload = ERR_PAYLOAD;            // anything unmatched goes out as error
                if (!lane_i.ctrl) begin
                        blk_d.hdr     = SYNC_DATA;      // data word, bytes as they are
                        blk_d.payload = lane_i.data;
                end else begin
                        case ({lane_i.idle, lane_i.start, lane_i.term, lane_i.err})
                        5'b10000: begin
                                if (lane_i.keep == 8'h00)
                                        blk_d.payload = IDLE_PAYLOAD;
                        end
                        5'b00100: begin
                                if (lane_i.keep == 8'hfe)       // bytes 1..7 keep their place
                                        blk_d.payload = {lane_i.data[63:8], BT_START0};
                        end
                        5'b01000: begin
                                if (lane_i.keep == 8'he0)       // c0..c3 idle, o0 zero, d5..d7
                                        blk_d.payload = {lane_i.data[63:40], 32'h0, BT_START4};
                        end
                        5'b00010: begin
                                if (term_ok) begin
                                        blk_d.payload      = '0;        // trailing idle codes are zero
                                        blk_d.payload[7:0] = TERM_TYPES[term_n[2:0]];
                                        for (int i = 0; i < 7; i++) begin
                                                if (lane_i.keep[i])     // byte i moves up by one
                                                        blk_d.payload[8*(i+1) +: 8] =
                                                                lane_i.data[8*i +: 8];
                                        end
                                end
                        end
                        default: ;                      // err word or mixed flags
                        endcase
                end
        end

        always_ff @(posedge logic_clk) begin
                if (!rst_n_i) begin
                        blk_o.hdr     <= SYNC_CTRL;             // idle block out of reset
                        blk_o.payload <= IDLE_PAYLOAD;
                end else begin
                        blk_o <= blk_d;
                end
        end

endmodule

`default_nettype wire

/* pcs_loop_top.f */
hdl/pcs_line_pkg.sv
hdl/pcs_lane_pkg.sv
hdl/pcs_scrambler.sv
hdl/pcs_tx_encode.sv
hdl/pcs_rx_decode.sv
hdl/pcs_block_lock.sv
hdl/pcs_loop_top.sv
tests/pcs_loop_properties.sv
tests/pcs_loop_tb.sv

/* tests/pcs_loop_properties.sv */
`default_nettype none

module pcs_loop_properties (
        input  wire                           logic_clk,
        input  wire                           rst_n_i,
        input  wire pcs_line_pkg::pcs_block_t tx_blk_i,       // serdes_tx_o of the top
        input  wire pcs_lane_pkg::pcs_lane_t  rx_lane_i,      // mac_rx_o of the top
        input  wire                           rx_valid_i,
        input  wire                           lock_i
);
        import pcs_line_pkg::*;
        import pcs_lane_pkg::*;

        tx_hdr_legal: assert property (@(posedge logic_clk) disable iff (!rst_n_i)
                tx_blk_i.hdr == SYNC_DATA || tx_blk_i.hdr == SYNC_CTRL)
                else $error("illegal header on serdes_tx_o");

        valid_needs_lock: assert property (@(posedge logic_clk) disable iff (!rst_n_i)
                rx_valid_i |-> lock_i)
                else $error("mac_rx_valid_o without block lock");

        start_term_apart: assert property (@(posedge logic_clk) disable iff (!rst_n_i)
                !((|rx_lane_i.start) && rx_lane_i.term))
                else $error("start and term set in one word");

        idle_keep_zero: assert property (@(posedge logic_clk) disable iff (!rst_n_i)
                rx_lane_i.idle |-> rx_lane_i.keep == 8'h00)
                else $error("idle word with bytes kept");

endmodule

bind pcs_loop_top pcs_loop_properties m_props (
        .logic_clk  (logic_clk),
        .rst_n_i    (rst_n_i),
        .tx_blk_i   (serdes_tx_o),
        .rx_lane_i  (mac_rx_o),
        .rx_valid_i (mac_rx_valid_o),
        .lock_i     (block_lock_o)
);

`default_nettype wire

/* tests/pcs_loop_tb.sv */
`default_nettype none

module pcs_loop_tb;
        import pcs_line_pkg::*;
        import pcs_lane_pkg::*;

        localparam int CLK_PERIOD = 40;
        localparam int RX_LAT     = 4;                  // mac_tx to mac_rx over the line loop
        localparam int INJ_LAT    = 2;                  // serdes_rx to mac_rx
        localparam int LOOP_LAT   = 5;                  // serdes_rx to serdes_tx in loopback
        localparam int WAIT_MAX   = 200;

        logic       logic_clk, rst_n, loopback, line_loop;
        pcs_lane_t  mac_tx, mac_rx;
        pcs_block_t inj_blk, serdes_rx, serdes_tx;
        logic       mac_rx_valid, block_lock;

        logic [31:0] lfsr_q;
        logic [57:0] mscr_q, mdscr_q;                   // model scrambler, model descrambler
        int          cyc, win0, lat;
        logic        lock_seen, valid_seen;
        pcs_block_t  tx_seen;
        pcs_lane_t   exp_q[$];
        bit          chk_q[$];

        assign serdes_rx = line_loop ? serdes_tx : inj_blk;   // wire loop or injected blocks

        pcs_loop_top dut_i (
                .logic_clk      (logic_clk),
                .rst_n_i        (rst_n),
                .loopback_i     (loopback),
                .mac_tx_i       (mac_tx),
                .serdes_rx_i    (serdes_rx),
                .serdes_tx_o    (serdes_tx),
                .mac_rx_o       (mac_rx),
                .mac_rx_valid_o (mac_rx_valid),
                .block_lock_o   (block_lock)
        );

        initial begin
                logic_clk = 1'b0;
                forever #(CLK_PERIOD/2) logic_clk = ~logic_clk;
        end

        function automatic logic [63:0] rand_bits(input int n);
                logic [63:0] v;
                logic        fb;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];   // taps 32 22 2 1
                        lfsr_q = {lfsr_q[30:0], fb};
                        v[i] = fb;
                end
                return v;
        endfunction

        function automatic pcs_lane_t idle_word();
                pcs_lane_t w;
                w = '0;
                w.ctrl = 1'b1;
                w.idle = 1'b1;
                return w;
        endfunction

        function automatic pcs_lane_t err_word();
                pcs_lane_t w;
                w = '0;
                w.ctrl = 1'b1;
                w.err = 1'b1;
                return w;
        endfunction

        function automatic pcs_lane_t data_word(input logic [63:0] d);
                pcs_lane_t w;
                w = '0;
                w.data = d;
                w.keep = 8'hff;
                return w;
        endfunction

        function automatic pcs_lane_t start_word(input bit lane4, input logic [63:0] d);
                pcs_lane_t w;
                w = '0;
                w.ctrl  = 1'b1;
                w.start = lane4 ? 2'b10 : 2'b01;
                w.keep  = lane4 ? 8'he0 : 8'hfe;
                w.data  = d;                            // bytes outside keep are dropped
                return w;
        endfunction

        function automatic pcs_lane_t term_word(input int n, input logic [63:0] d);
                pcs_lane_t w;
                w = '0;
                w.ctrl = 1'b1;
                w.term = 1'b1;
                w.data = d;
                for (int i = 0; i < 8; i++)
                        w.keep[i] = (i < n);            // n bytes before the T code
                return w;
        endfunction

        // 10GBASE-R block formats written out per word kind
        function automatic pcs_block_t ref_encode(input pcs_lane_t w);
                pcs_block_t b;
                int         n;
                n = 0;
                b.hdr = SYNC_CTRL;
                b.payload = {{8{7'h1e}}, 8'h1e};        // error block by default
                if (!w.ctrl) begin
                        b.hdr = SYNC_DATA;
                        b.payload = w.data;
                end else if (w.idle) begin
                        b.payload = {56'h0, 8'h1e};
                end else if (w.start == 2'b01) begin
                        b.payload = {w.data[63:8], 8'h78};
                end else if (w.start == 2'b10) begin
                        b.payload = {w.data[63:40], 4'h0, 28'h0, 8'h33};    // o0 then c0..c3
                end else if (w.term) begin
                        for (int i = 0; i < 8; i++)
                                n += int'(w.keep[i]);
                        b.payload = '0;
                        case (n)
                        0: b.payload[7:0] = 8'h87;
                        1: b.payload[7:0] = 8'h99;
                        2: b.payload[7:0] = 8'haa;
                        3: b.payload[7:0] = 8'hb4;
                        4: b.payload[7:0] = 8'hcc;
                        5: b.payload[7:0] = 8'hd2;
                        6: b.payload[7:0] = 8'he1;
                        default: b.payload[7:0] = 8'hff;
                        endcase
                        for (int i = 0; i < n; i++)
                                b.payload[8*i+8 +: 8] = w.data[8*i +: 8];
                end
                return b;
        endfunction

        // x^58 + x^39 + 1, st[k] holds the line bit from k+1 steps back
        task automatic scramble(input logic [63:0] p, input bit desc, inout logic [57:0] st,
                                output logic [63:0] r);
                for (int i = 0; i < 64; i++) begin
                        r[i] = p[i] ^ st[38] ^ st[57];
                        st = {st[56:0], desc ? p[i] : r[i]};
                end
        endtask

        task automatic value_error(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
                $display("Error t=%0t %s got %h expected %h", $time, name, got, exp);
                $display("Done: errors found");
                $fatal(1, "mismatch on %s", name);
        endtask

        task automatic run_error(input string what);
                $display("%s at t=%0t", what, $time);
                $display("Done: errors found");
                $fatal(1, "%s", what);
        endtask

        task automatic check_word(input pcs_lane_t e);
                assert ({mac_rx.ctrl, mac_rx.idle, mac_rx.start, mac_rx.term, mac_rx.err} ===
                        {e.ctrl, e.idle, e.start, e.term, e.err})
                else value_error("mac_rx_o flags", {mac_rx.ctrl, mac_rx.idle, mac_rx.start,
                        mac_rx.term, mac_rx.err}, {e.ctrl, e.idle, e.start, e.term, e.err});
                assert (mac_rx.keep === e.keep)
                else value_error("mac_rx_o.keep", mac_rx.keep, e.keep);
                for (int i = 0; i < 8; i++) begin
                        if (e.keep[i])
                                assert (mac_rx.data[8*i +: 8] === e.data[8*i +: 8])
                                else value_error("mac_rx_o.data", mac_rx.data, e.data);
                end
        endtask

        // one line cycle: sample at the falling edge, check the word due now, then drive
        task automatic step(input pcs_lane_t tx_w, input pcs_block_t rx_b, input pcs_lane_t exp_w,
                            input bit chk);
                pcs_lane_t e;
                bit        c;
                @(negedge logic_clk);
                lock_seen  = block_lock;
                valid_seen = mac_rx_valid;
                tx_seen    = serdes_tx;
                exp_q.push_back(exp_w);
                chk_q.push_back(chk);
                if (exp_q.size() > lat) begin
                        e = exp_q.pop_front();
                        c = chk_q.pop_front();
                        if (c)
                                check_word(e);
                end
                mac_tx  = tx_w;
                inj_blk = rx_b;
                cyc++;
        endtask

        task automatic inject(input pcs_block_t raw, input pcs_lane_t exp_w, input bit chk);
                pcs_block_t b;
                b.hdr = raw.hdr;                        // header bypasses the scrambler
                scramble(raw.payload, 1'b0, mscr_q, b.payload);
                step(idle_word(), b, exp_w, chk);
        endtask

        task automatic apply_reset();
                rst_n = 1'b0;
                repeat (4) begin
                        @(negedge logic_clk);
                        assert (!block_lock)
                        else value_error("block_lock_o in reset", block_lock, 0);
                        assert (!mac_rx_valid)
                        else value_error("mac_rx_valid_o in reset", mac_rx_valid, 0);
                end
                rst_n = 1'b1;
                cyc = 0;
                exp_q.delete();
                chk_q.delete();
        endtask

        task automatic acquire_lock();
                int n;
                n = 0;
                lat = RX_LAT;
                lock_seen = 1'b0;
                while (!lock_seen) begin
                        if (n >= WAIT_MAX)
                                run_error("block lock never came up on idle traffic");
                        step(idle_word(), inj_blk, idle_word(), 1'b1);
                        if (!lock_seen)
                                assert (!valid_seen) else value_error("mac_rx_valid_o", 1, 0);
                        n++;
                end
                win0 = cyc - 1;                         // next header is window slot 0
                assert (win0 == LOCK_GOOD_N - 1) else value_error("block_lock_o rise", win0, 63);
                repeat (4) begin
                        step(idle_word(), inj_blk, idle_word(), 1'b1);
                        assert (valid_seen) else value_error("mac_rx_valid_o", valid_seen, 1);
                end
        endtask

        task automatic frame_round_trip();
                pcs_lane_t w;
                int        nd;
                for (int n = 0; n < 8; n++) begin
                        w = start_word(n[0], rand_bits(64));    // odd n starts in lane 4
                        step(w, inj_blk, w, 1'b1);
                        nd = 1 + int'(rand_bits(2));
                        repeat (nd) begin
                                w = data_word(rand_bits(64));
                                step(w, inj_blk, w, 1'b1);
                                assert (valid_seen) else value_error("mac_rx_valid_o", 0, 1);
                        end
                        w = term_word(n, rand_bits(64));
                        step(w, inj_blk, w, 1'b1);
                        repeat (2) step(idle_word(), inj_blk, idle_word(), 1'b1);
                end
                repeat (RX_LAT) step(idle_word(), inj_blk, idle_word(), 1'b1);   // drain
        endtask

        task automatic unknown_type();
                pcs_block_t  b;
                logic [63:0] r;
                line_loop = 1'b0;
                lat = INJ_LAT;
                exp_q.delete();
                chk_q.delete();
                repeat (2) inject(ref_encode(idle_word()), idle_word(), 1'b0);  // rx resync
                b.hdr = SYNC_CTRL;
                r = rand_bits(56);
                b.payload = {r[55:0], 8'h55};           // not a known type byte
                inject(b, err_word(), 1'b1);
                repeat (3) inject(ref_encode(idle_word()), idle_word(), 1'b1);
        endtask

        task automatic header_errors();
                pcs_block_t b;
                while ((cyc - win0) % LOCK_WIN_N != 0)  // align to a lock window
                        inject(ref_encode(idle_word()), idle_word(), 1'b1);
                for (int s = 0; s < LOCK_WIN_N; s++) begin
                        b = ref_encode(idle_word());
                        if (s < LOCK_BAD_N - 1)
                                b.hdr = s[0] ? 2'b11 : 2'b00;
                        inject(b, (s < LOCK_BAD_N - 1) ? err_word() : idle_word(), 1'b1);
                        assert (lock_seen) else run_error("block lock lost with 15 bad headers");
                end
                for (int s = 0; s < LOCK_BAD_N; s++) begin
                        b = ref_encode(idle_word());
                        b.hdr = s[0] ? 2'b00 : 2'b11;
                        inject(b, err_word(), 1'b1);
                        assert (lock_seen) else run_error("block lock lost too early");
                end
                inject(ref_encode(idle_word()), idle_word(), 1'b1);
                assert (!lock_seen && !valid_seen)
                else run_error("block lock kept after 16 bad headers");
                repeat (3) inject(ref_encode(idle_word()), idle_word(), 1'b1);
        endtask

        task automatic loopback_path();
                pcs_block_t  sent[$];
                logic [63:0] pay;
                int          k;
                loopback = 1'b1;
                mdscr_q = '1;
                for (int n = 0; n < 8; n++) begin
                        sent.push_back(ref_encode(start_word(n[1], rand_bits(64))));
                        sent.push_back(ref_encode(data_word(rand_bits(64))));
                        sent.push_back(ref_encode(term_word(n, rand_bits(64))));
                        sent.push_back(ref_encode(idle_word()));
                end
                for (int i = 0; i < sent.size() + LOOP_LAT; i++) begin
                        inject((i < sent.size()) ? sent[i] : ref_encode(idle_word()),
                               idle_word(), 1'b0);
                        scramble(tx_seen.payload, 1'b1, mdscr_q, pay);
                        k = i - LOOP_LAT;
                        if (k >= 0 && k < sent.size()) begin
                                assert (tx_seen.hdr === sent[k].hdr)
                                else value_error("serdes_tx_o.hdr", tx_seen.hdr, sent[k].hdr);
                                assert (pay === sent[k].payload)
                                else value_error("serdes_tx_o.payload", pay, sent[k].payload);
                        end
                end
        endtask

        initial begin
                rst_n     = 1'b0;
                loopback  = 1'b0;
                line_loop = 1'b1;
                mac_tx    = idle_word();
                inj_blk   = ref_encode(idle_word());
                lfsr_q    = 32'h37f62bd1;
                mscr_q    = '1;
                mdscr_q   = '1;
                cyc       = 0;
                win0      = 0;
                lat       = RX_LAT;
                apply_reset();
                acquire_lock();
                frame_round_trip();
                unknown_type();
                header_errors();
                loopback_path();
                $display("Done: no errors");
                $finish;
        end

        initial begin
                #(CLK_PERIOD * 5000);
                run_error("simulation ran past its time limit");
        end

endmodule

`default_nettype wire
